//--- logic/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] address_t;
   typedef logic [4:0]  register_index_t;
   typedef logic [6:0]  opcode_t;

   // 4 KiB of word storage
   localparam int memory_words      = 1024;
   localparam int memory_index_bits = $clog2(memory_words);

   // ----------------------------------------
   // base opcodes
   // ----------------------------------------
   localparam opcode_t opcode_lui    = 7'b0110111;
   localparam opcode_t opcode_auipc  = 7'b0010111;
   localparam opcode_t opcode_jal    = 7'b1101111;
   localparam opcode_t opcode_jalr   = 7'b1100111;
   localparam opcode_t opcode_branch = 7'b1100011;
   localparam opcode_t opcode_load   = 7'b0000011;
   localparam opcode_t opcode_store  = 7'b0100011;
   localparam opcode_t opcode_op_imm = 7'b0010011;
   localparam opcode_t opcode_op     = 7'b0110011;
   localparam opcode_t opcode_fence  = 7'b0001111;
   localparam opcode_t opcode_system = 7'b1110011;

   typedef enum logic [3:0] {
      class_lui,
      class_auipc,
      class_jal,
      class_jalr,
      class_branch,
      class_load,
      class_store,
      class_alu_imm,
      class_alu_reg,
      class_fence,
      class_system,
      class_illegal
   } instruction_class_t;

   typedef enum logic [1:0] {
      state_idle,
      state_wait_instruction,
      state_wait_load,
      state_halted
   } execute_state_t;

endpackage

`default_nettype wire

//--- logic/rv32i_if.sv
`timescale 1ns/1ps
`default_nettype none

// data side of the word memory
interface memory_bus_if;
   import rv32i_pkg::*;

   logic     read_enable;
   address_t read_address;
   word_t    read_value;
   logic     write_enable;
   address_t write_address;
   word_t    write_value;

   modport requester (output read_enable, read_address, write_enable, write_address,
                      write_value, input read_value);
   modport responder (input read_enable, read_address, write_enable, write_address,
                      write_value, output read_value);
endinterface

// fields of the current instruction, all combinational
interface decoded_if;
   import rv32i_pkg::*;

   instruction_class_t instruction_class;
   register_index_t    rd;
   register_index_t    rs1;
   register_index_t    rs2;
   logic [2:0]         funct3;
   logic               funct7_alt;
   word_t              immediate;

   modport source (output instruction_class, rd, rs1, rs2, funct3, funct7_alt, immediate);
   modport sink (input instruction_class, rd, rs1, rs2, funct3, funct7_alt, immediate);
endinterface

interface register_if;
   import rv32i_pkg::*;

   register_index_t rs1_address;
   register_index_t rs2_address;
   word_t           rs1_value;
   word_t           rs2_value;
   logic            write_enable;
   register_index_t write_address;
   word_t           write_value;

   modport user (output rs1_address, rs2_address, write_enable, write_address, write_value,
                 input rs1_value, rs2_value);
   modport owner (input rs1_address, rs2_address, write_enable, write_address, write_value,
                  output rs1_value, rs2_value);
endinterface

`default_nettype wire

//--- logic/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                fetch_read_enable,
   input  rv32i_pkg::address_t fetch_address,
   output rv32i_pkg::word_t    fetch_value,
   memory_bus_if.responder     data,
   input  logic                load_enable,
   input  rv32i_pkg::address_t load_address,
   input  rv32i_pkg::word_t    load_value,
   input  rv32i_pkg::address_t inspect_address,
   output rv32i_pkg::word_t    inspect_value
);
   import rv32i_pkg::*;

   word_t storage [memory_words];

   // byte address to word index, low two bits dropped
   function automatic logic [memory_index_bits-1:0] word_index(input address_t address);
      return address[memory_index_bits+1:2];
   endfunction

   // loader has priority over the core
   always_ff @(posedge clock) begin
      if (load_enable) begin
         storage[word_index(load_address)] <= load_value;
      end else if (data.write_enable) begin
         storage[word_index(data.write_address)] <= data.write_value;
      end
   end

   // registered read ports, value holds until the next read
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         fetch_value     <= '0;
         data.read_value <= '0;
      end else begin
         if (fetch_read_enable) begin
            fetch_value <= storage[word_index(fetch_address)];
         end
         if (data.read_enable) begin
            data.read_value <= storage[word_index(data.read_address)];
         end
      end
   end

   assign inspect_value = storage[word_index(inspect_address)];

endmodule

`default_nettype wire

//--- logic/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                fetch_enable,
   input  logic                pc_write,
   input  rv32i_pkg::address_t next_pc,
   output logic                fetch_read_enable,
   output rv32i_pkg::address_t fetch_address,
   input  rv32i_pkg::word_t    fetch_value,
   output rv32i_pkg::word_t    instruction,
   output logic                instruction_valid,
   output rv32i_pkg::address_t pc
);
   import rv32i_pkg::*;

   word_t instruction_held;

   assign fetch_read_enable = fetch_enable;
   assign fetch_address     = pc;

   // ----------------------------------------
   // program counter and valid strobe
   // ----------------------------------------
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pc                <= '0;
         instruction_valid <= 1'b0;
      end else begin
         if (pc_write) begin
            pc <= next_pc;
         end
         // memory answers one cycle after the read
         instruction_valid <= fetch_enable;
      end
   end

   always_ff @(posedge clock) begin
      if (instruction_valid) begin
         instruction_held <= fetch_value;
      end
   end

   // returned word is used directly in the valid cycle, the held copy after that
   assign instruction = instruction_valid ? fetch_value : instruction_held;

endmodule

`default_nettype wire

//--- logic/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  rv32i_pkg::word_t instruction,
   decoded_if.source        decoded
);
   import rv32i_pkg::*;

   opcode_t    opcode;
   logic [6:0] funct7;
   logic       funct7_legal;
   logic       is_shift;

   assign opcode       = instruction[6:0];
   assign funct7       = instruction[31:25];
   assign funct7_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
   // funct3 of 001 or 101
   assign is_shift     = (instruction[13:12] == 2'b01);

   assign decoded.rd         = instruction[11:7];
   assign decoded.rs1        = instruction[19:15];
   assign decoded.rs2        = instruction[24:20];
   assign decoded.funct3     = instruction[14:12];
   assign decoded.funct7_alt = instruction[30];

   always_comb begin
      case (opcode)
         opcode_lui:    decoded.instruction_class = class_lui;
         opcode_auipc:  decoded.instruction_class = class_auipc;
         opcode_jal:    decoded.instruction_class = class_jal;
         opcode_jalr:   decoded.instruction_class = class_jalr;
         opcode_branch: decoded.instruction_class = class_branch;
         opcode_load:   decoded.instruction_class = class_load;
         opcode_store:  decoded.instruction_class = class_store;
         opcode_op_imm:
            decoded.instruction_class = (!is_shift || funct7_legal) ? class_alu_imm : class_illegal;
         opcode_op:     decoded.instruction_class = funct7_legal ? class_alu_reg : class_illegal;
         opcode_fence:  decoded.instruction_class = class_fence;
         opcode_system: decoded.instruction_class = class_system;
         default:       decoded.instruction_class = class_illegal;
      endcase
   end

   // immediate format follows the class
   always_comb begin
      case (decoded.instruction_class)
         class_jalr, class_load, class_alu_imm:
            decoded.immediate = {{20{instruction[31]}}, instruction[31:20]};
         class_store:
            decoded.immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
         class_branch:
            decoded.immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                                 instruction[30:25], instruction[11:8], 1'b0};
         class_lui, class_auipc:
            decoded.immediate = {instruction[31:12], 12'b0};
         class_jal:
            decoded.immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                                 instruction[20], instruction[30:21], 1'b0};
         default:
            decoded.immediate = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input logic       clock,
   input logic       rst_n,
   register_if.owner port
);
   import rv32i_pkg::*;

   // x0 has no storage
   word_t registers [1:31];

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            registers[i] <= '0;
         end
      end else if (port.write_enable && (port.write_address != '0)) begin
         registers[port.write_address] <= port.write_value;
      end
   end

   assign port.rs1_value = (port.rs1_address == '0) ? '0 : registers[port.rs1_address];
   assign port.rs2_value = (port.rs2_address == '0) ? '0 : registers[port.rs2_address];

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                run,
   input  logic                instruction_valid,
   input  rv32i_pkg::address_t pc,
   decoded_if.sink             decoded,
   register_if.user            registers,
   memory_bus_if.requester     data,
   output logic                fetch_enable,
   output logic                pc_write,
   output rv32i_pkg::address_t next_pc,
   output logic                halted,
   output logic                illegal
);
   import rv32i_pkg::*;

   execute_state_t state;
   execute_state_t state_next;
   logic           retire_cycle;
   logic           writes_register;
   logic           branch_taken;
   word_t          operand_a;
   word_t          operand_b;
   word_t          shift_right_arith;
   word_t          alu_result;
   address_t       pc_plus_4;
   address_t       effective_address;

   assign registers.rs1_address = decoded.rs1;
   assign registers.rs2_address = decoded.rs2;

   assign retire_cycle      = (state == state_wait_instruction) && instruction_valid;
   assign pc_plus_4         = pc + 32'd4;
   assign operand_a         = registers.rs1_value;
   assign effective_address = operand_a + decoded.immediate;

   // ----------------------------------------
   // ALU
   // ----------------------------------------
   assign operand_b = (decoded.instruction_class == class_alu_reg) ? registers.rs2_value
                                                                   : decoded.immediate;
   assign shift_right_arith = $signed(operand_a) >>> operand_b[4:0];

   always_comb begin
      case (decoded.funct3)
         3'b000: begin
            // sub only exists in the register form
            if (decoded.instruction_class == class_alu_reg && decoded.funct7_alt) begin
               alu_result = operand_a - operand_b;
            end else begin
               alu_result = operand_a + operand_b;
            end
         end
         3'b001: alu_result = operand_a << operand_b[4:0];
         3'b010: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
         3'b011: alu_result = {31'b0, operand_a < operand_b};
         3'b100: alu_result = operand_a ^ operand_b;
         3'b101: alu_result = decoded.funct7_alt ? shift_right_arith : operand_a >> operand_b[4:0];
         3'b110: alu_result = operand_a | operand_b;
         default: alu_result = operand_a & operand_b;
      endcase
   end

   // ----------------------------------------
   // branches and jumps
   // ----------------------------------------
   always_comb begin
      case (decoded.funct3)
         3'b000: branch_taken = operand_a == registers.rs2_value;
         3'b001: branch_taken = operand_a != registers.rs2_value;
         3'b100: branch_taken = $signed(operand_a) < $signed(registers.rs2_value);
         3'b101: branch_taken = $signed(operand_a) >= $signed(registers.rs2_value);
         3'b110: branch_taken = operand_a < registers.rs2_value;
         3'b111: branch_taken = operand_a >= registers.rs2_value;
         default: branch_taken = 1'b0;
      endcase
   end

   always_comb begin
      case (decoded.instruction_class)
         class_jal:    next_pc = pc + decoded.immediate;
         class_jalr:   next_pc = {effective_address[31:1], 1'b0};
         class_branch: next_pc = branch_taken ? pc + decoded.immediate : pc_plus_4;
         default:      next_pc = pc_plus_4;
      endcase
   end

   // ----------------------------------------
   // memory access and write-back
   // ----------------------------------------
   assign data.read_enable   = retire_cycle && (decoded.instruction_class == class_load);
   assign data.read_address  = effective_address;
   assign data.write_enable  = retire_cycle && (decoded.instruction_class == class_store);
   assign data.write_address = effective_address;
   assign data.write_value   = registers.rs2_value;

   assign writes_register = decoded.instruction_class inside {class_lui, class_auipc, class_jal,
                                                               class_jalr, class_alu_imm,
                                                               class_alu_reg};

   assign registers.write_enable  = (retire_cycle && writes_register) ||
                                    (state == state_wait_load);
   assign registers.write_address = decoded.rd;

   always_comb begin
      case (decoded.instruction_class)
         class_lui:             registers.write_value = decoded.immediate;
         class_auipc:           registers.write_value = pc + decoded.immediate;
         class_jal, class_jalr: registers.write_value = pc_plus_4;
         class_load:            registers.write_value = data.read_value;
         default:               registers.write_value = alu_result;
      endcase
   end

   // ----------------------------------------
   // sequencing FSM
   // ----------------------------------------
   always_comb begin
      state_next   = state;
      fetch_enable = 1'b0;
      pc_write     = 1'b0;
      case (state)
         state_idle: begin
            if (run) begin
               fetch_enable = 1'b1;
               state_next   = state_wait_instruction;
            end
         end
         state_wait_instruction: begin
            if (instruction_valid) begin
               case (decoded.instruction_class)
                  class_load:                  state_next = state_wait_load;
                  class_system, class_illegal: state_next = state_halted;
                  default: begin
                     pc_write   = 1'b1;
                     state_next = state_idle;
                  end
               endcase
            end
         end
         state_wait_load: begin
            pc_write   = 1'b1;
            state_next = state_idle;
         end
         default: state_next = state_halted;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state   <= state_idle;
         halted  <= 1'b0;
         illegal <= 1'b0;
      end else begin
         state <= state_next;
         // both flags are sticky until reset
         if (state_next == state_halted) begin
            halted <= 1'b1;
         end
         if (retire_cycle && (decoded.instruction_class == class_illegal)) begin
            illegal <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/rv32i_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core_top (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                run,
   input  logic                load_enable,
   input  rv32i_pkg::address_t load_address,
   input  rv32i_pkg::word_t    load_value,
   input  rv32i_pkg::address_t inspect_address,
   output rv32i_pkg::word_t    inspect_value,
   output logic                halted,
   output logic                illegal
);
   import rv32i_pkg::*;

   logic     fetch_read_enable;
   address_t fetch_address;
   word_t    fetch_value;
   logic     fetch_enable;
   logic     pc_write;
   address_t next_pc;
   word_t    instruction;
   logic     instruction_valid;
   address_t pc;

   memory_bus_if data_bus ();
   decoded_if    decoded ();
   register_if   registers ();

   memory memory_1 (
      .clock             (clock),
      .rst_n             (rst_n),
      .fetch_read_enable (fetch_read_enable),
      .fetch_address     (fetch_address),
      .fetch_value       (fetch_value),
      .data              (data_bus.responder),
      .load_enable       (load_enable),
      .load_address      (load_address),
      .load_value        (load_value),
      .inspect_address   (inspect_address),
      .inspect_value     (inspect_value)
   );

   fetch fetch_1 (
      .clock             (clock),
      .rst_n             (rst_n),
      .fetch_enable      (fetch_enable),
      .pc_write          (pc_write),
      .next_pc           (next_pc),
      .fetch_read_enable (fetch_read_enable),
      .fetch_address     (fetch_address),
      .fetch_value       (fetch_value),
      .instruction       (instruction),
      .instruction_valid (instruction_valid),
      .pc                (pc)
   );

   decode decode_1 (
      .instruction (instruction),
      .decoded     (decoded.source)
   );

   register_file register_file_1 (
      .clock (clock),
      .rst_n (rst_n),
      .port  (registers.owner)
   );

   execute execute_1 (
      .clock             (clock),
      .rst_n             (rst_n),
      .run               (run),
      .instruction_valid (instruction_valid),
      .pc                (pc),
      .decoded           (decoded.sink),
      .registers         (registers.user),
      .data              (data_bus.requester),
      .fetch_enable      (fetch_enable),
      .pc_write          (pc_write),
      .next_pc           (next_pc),
      .halted            (halted),
      .illegal           (illegal)
   );

endmodule

`default_nettype wire

//--- sim/tb_rv32i.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i;

   typedef logic [31:0] word_t;

   localparam int clock_half_period = 10;
   localparam int reset_cycles      = 10;
   localparam int halt_timeout      = 2000;
   localparam int seed_start        = 70;

   localparam int lui_opcode    = 'h37;
   localparam int auipc_opcode  = 'h17;
   localparam int jalr_opcode   = 'h67;
   localparam int op_imm_opcode = 'h13;
   localparam int load_opcode   = 'h03;

   localparam word_t fence_word  = 32'h0000000f;
   localparam word_t ebreak_word = 32'h00100073;

   logic  clock;
   logic  rst_n;
   logic  run;
   logic  load_enable;
   word_t load_address;
   word_t load_value;
   word_t inspect_address;
   word_t inspect_value;
   logic  halted;
   logic  illegal;

   integer seed;
   word_t  program_words [$];

   // funct3 per alu op in the order add sub sll slt sltu xor srl sra or and
   int alu_funct3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
   // funct3 per branch kind in the order eq ne lt ge ltu geu
   int branch_funct3 [6] = '{0, 1, 4, 5, 6, 7};

   rv32i_core_top UUT (
      .clock           (clock),
      .rst_n           (rst_n),
      .run             (run),
      .load_enable     (load_enable),
      .load_address    (load_address),
      .load_value      (load_value),
      .inspect_address (inspect_address),
      .inspect_value   (inspect_value),
      .halted          (halted),
      .illegal         (illegal)
   );

   always #clock_half_period clock = ~clock;

   // ----------------------------------------
   // instruction encoders
   // ----------------------------------------
   function automatic word_t r_type(input int funct7, input int rs2, input int rs1,
                                    input int funct3, input int rd);
      return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t i_type(input int imm, input int rs1, input int funct3,
                                    input int rd, input int opcode);
      return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
   endfunction

   function automatic word_t b_type(input int offset, input int rs2, input int rs1,
                                    input int funct3);
      return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0], offset[4:1],
              offset[11], 7'b1100011};
   endfunction

   function automatic word_t u_type(input int upper, input int rd, input int opcode);
      return {upper[19:0], rd[4:0], opcode[6:0]};
   endfunction

   function automatic word_t j_type(input int offset, input int rd);
      return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic word_t add_immediate(input int rd, input int rs1, input int imm);
      return i_type(imm, rs1, 0, rd, op_imm_opcode);
   endfunction

   // sw rs2, address(x0)
   function automatic word_t store_word(input int rs2, input int address);
      return {address[11:5], rs2[4:0], 5'd0, 3'b010, address[4:0], 7'b0100011};
   endfunction

   function automatic word_t load_word(input int rd, input int rs1, input int offset);
      return i_type(offset, rs1, 2, rd, load_opcode);
   endfunction

   // ----------------------------------------
   // reference rules
   // ----------------------------------------
   function automatic word_t alu_reference(input int op, input word_t a, input word_t b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return a << b[4:0];
         3: return {31'b0, $signed(a) < $signed(b)};
         4: return {31'b0, a < b};
         5: return a ^ b;
         6: return a >> b[4:0];
         7: return $signed(a) >>> b[4:0];
         8: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_reference(input int kind, input word_t a, input word_t b);
      case (kind)
         0: return a == b;
         1: return a != b;
         2: return $signed(a) < $signed(b);
         3: return $signed(a) >= $signed(b);
         4: return a < b;
         default: return a >= b;
      endcase
   endfunction

   // ----------------------------------------
   // driver and check tasks
   // ----------------------------------------
   task automatic check_value(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic emit(input word_t instruction);
      program_words.push_back(instruction);
   endtask

   // lui then addi with the upper part rounded for the sign of the low 12 bits
   task automatic emit_constant(input int rd, input word_t value);
      word_t upper;
      upper = (value + 32'h800) >> 12;
      emit(u_type(int'(upper), rd, lui_opcode));
      emit(add_immediate(rd, rd, int'(value)));
   endtask

   task automatic write_word(input word_t address, input word_t value);
      @(posedge clock);
      load_enable  <= 1'b1;
      load_address <= address;
      load_value   <= value;
      @(posedge clock);
      load_enable <= 1'b0;
   endtask

   task automatic read_word(input word_t address, output word_t value);
      @(posedge clock);
      inspect_address <= address;
      @(negedge clock);
      value = inspect_value;
   endtask

   task automatic check_word(input word_t address, input word_t expected);
      word_t value;
      read_word(address, value);
      check_value($sformatf("mem[%h]", address), value, expected);
   endtask

   task automatic load_program();
      foreach (program_words[i]) begin
         write_word(word_t'(4 * i), program_words[i]);
      end
      program_words.delete();
   endtask

   task automatic pulse_reset();
      @(posedge clock);
      rst_n <= 1'b0;
      repeat (reset_cycles) @(posedge clock);
      rst_n <= 1'b1;
   endtask

   task automatic wait_for_halt(input int limit);
      int  count;
      logic done;
      count = 0;
      done  = 1'b0;
      while (!done) begin
         @(negedge clock);
         if (halted) begin
            done = 1'b1;
         end else if (count >= limit) begin
            $display("timeout: the core did not halt within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "run aborted");
         end else begin
            count++;
         end
      end
   endtask

   task automatic start_and_wait(input logic expect_illegal);
      @(posedge clock);
      run <= 1'b1;
      wait_for_halt(halt_timeout);
      @(posedge clock);
      run <= 1'b0;
      @(negedge clock);
      check_value("illegal", word_t'(illegal), word_t'(expect_illegal));
   endtask

   task automatic run_program(input logic expect_illegal);
      load_program();
      pulse_reset();
      start_and_wait(expect_illegal);
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic reset_and_run_gating();
      write_word(32'h400, 32'h12345678);
      emit(store_word(0, 'h400));
      emit(ebreak_word);
      load_program();
      pulse_reset();
      @(negedge clock);
      check_value("halted", word_t'(halted), 32'd0);
      check_value("illegal", word_t'(illegal), 32'd0);
      repeat (50) @(posedge clock);
      check_word(32'h400, 32'h12345678);
      check_value("halted", word_t'(halted), 32'd0);
      start_and_wait(1'b0);
      check_word(32'h400, 32'd0);
   endtask

   task automatic alu_operations();
      word_t a;
      word_t b;
      word_t r;
      word_t operand;
      word_t imm_code;
      word_t expected [$];
      for (int round = 0; round < 3; round++) begin
         a = $random(seed);
         b = $random(seed);
         expected.delete();
         emit_constant(1, a);
         emit_constant(2, b);
         for (int op = 0; op < 10; op++) begin
            emit(r_type((op == 1 || op == 7) ? 'h20 : 0, 2, 1, alu_funct3[op], 3));
            emit(store_word(3, 'h400 + 4 * expected.size()));
            expected.push_back(alu_reference(op, a, b));
         end
         for (int op = 0; op < 10; op++) begin
            r = $random(seed);
            if (op == 2 || op == 6 || op == 7) begin
               operand  = {27'b0, r[4:0]};
               imm_code = (op == 7) ? (32'h400 | operand) : operand;
            end else begin
               operand  = {{20{r[11]}}, r[11:0]};
               imm_code = operand;
            end
            if (op != 1) begin
               emit(i_type(int'(imm_code), 1, alu_funct3[op], 3, op_imm_opcode));
               emit(store_word(3, 'h400 + 4 * expected.size()));
               expected.push_back(alu_reference(op, a, operand));
            end
         end
         // x0 ignores the write
         emit(add_immediate(0, 1, 7));
         emit(store_word(0, 'h400 + 4 * expected.size()));
         expected.push_back(32'd0);
         emit(ebreak_word);
         run_program(1'b0);
         foreach (expected[i]) begin
            check_word(32'h400 + word_t'(4 * i), expected[i]);
         end
      end
   endtask

   task automatic branches_and_loops();
      word_t value [3];
      int    rs_a;
      int    rs_b;
      int    slot;
      // sum 1..10
      emit(add_immediate(1, 0, 0));
      emit(add_immediate(2, 0, 1));
      emit(add_immediate(3, 0, 11));
      emit(r_type(0, 2, 1, 0, 1));
      emit(add_immediate(2, 2, 1));
      emit(b_type(-8, 3, 2, 1));
      emit(store_word(1, 'h400));
      emit(ebreak_word);
      run_program(1'b0);
      check_word(32'h400, 32'd55);

      value[1] = $random(seed);
      value[2] = $random(seed);
      emit_constant(1, value[1]);
      emit_constant(2, value[2]);
      slot = 0;
      for (int kind = 0; kind < 6; kind++) begin
         for (int pair = 0; pair < 3; pair++) begin
            rs_a = (pair == 1) ? 2 : 1;
            rs_b = (pair == 0) ? 2 : 1;
            // marker 1 on the taken path and 2 on the fall-through
            emit(b_type(12, rs_b, rs_a, branch_funct3[kind]));
            emit(add_immediate(4, 0, 2));
            emit(j_type(8, 0));
            emit(add_immediate(4, 0, 1));
            emit(store_word(4, 'h500 + 4 * slot));
            slot++;
         end
      end
      emit(ebreak_word);
      run_program(1'b0);
      slot = 0;
      for (int kind = 0; kind < 6; kind++) begin
         for (int pair = 0; pair < 3; pair++) begin
            rs_a = (pair == 1) ? 2 : 1;
            rs_b = (pair == 0) ? 2 : 1;
            check_word(32'h500 + word_t'(4 * slot),
                       branch_reference(kind, value[rs_a], value[rs_b]) ? 32'd1 : 32'd2);
            slot++;
         end
      end
   endtask

   task automatic jumps_and_upper();
      word_t lui_upper;
      word_t auipc_upper;
      word_t auipc_pc;
      lui_upper   = $random(seed);
      auipc_upper = $random(seed);
      emit(j_type(12, 1));
      emit(add_immediate(5, 0, 1));
      emit(add_immediate(5, 0, 1));
      emit(store_word(1, 'h400));
      // odd target whose bit 0 is dropped
      emit(add_immediate(2, 0, 33));
      emit(i_type(0, 2, 0, 3, jalr_opcode));
      emit(add_immediate(5, 0, 1));
      emit(add_immediate(5, 0, 1));
      emit(store_word(3, 'h404));
      emit(u_type(int'(lui_upper), 6, lui_opcode));
      emit(store_word(6, 'h40c));
      auipc_pc = word_t'(4 * program_words.size());
      emit(u_type(int'(auipc_upper), 7, auipc_opcode));
      emit(store_word(7, 'h410));
      emit(i_type(27, 2, 0, 8, jalr_opcode));
      emit(add_immediate(5, 0, 1));
      emit(store_word(8, 'h414));
      emit(store_word(5, 'h418));
      emit(ebreak_word);
      run_program(1'b0);
      check_word(32'h400, 32'd4);
      check_word(32'h404, 32'd24);
      check_word(32'h40c, {lui_upper[19:0], 12'h000});
      check_word(32'h410, auipc_pc + {auipc_upper[19:0], 12'h000});
      check_word(32'h414, 32'd56);
      check_word(32'h418, 32'd0);
   endtask

   task automatic load_store_round_trip();
      word_t original [8];
      foreach (original[i]) begin
         original[i] = $random(seed);
         write_word(32'h600 + word_t'(4 * i), original[i]);
      end
      emit(add_immediate(10, 0, 'h600));
      for (int i = 0; i < 4; i++) begin
         emit(load_word(1, 10, 8 * i));
         emit(load_word(2, 10, 8 * i + 4));
         emit(fence_word);
         emit(r_type(0, 2, 1, 0, 3));
         emit(store_word(3, 'h700 + 4 * i));
      end
      emit(ebreak_word);
      run_program(1'b0);
      for (int i = 0; i < 4; i++) begin
         check_word(32'h700 + word_t'(4 * i), original[2 * i] + original[2 * i + 1]);
      end
      foreach (original[i]) begin
         check_word(32'h600 + word_t'(4 * i), original[i]);
      end
   endtask

   task automatic illegal_halt();
      write_word(32'h400, 32'd0);
      write_word(32'h404, 32'hdeadbeef);
      emit(add_immediate(1, 0, 'h5a));
      emit(store_word(1, 'h400));
      // custom-0 opcode is outside the supported set
      emit(32'h0000000b);
      emit(store_word(1, 'h404));
      emit(ebreak_word);
      run_program(1'b1);
      repeat (20) begin
         @(negedge clock);
         check_value("halted", word_t'(halted), 32'd1);
         check_value("illegal", word_t'(illegal), 32'd1);
      end
      check_word(32'h400, 32'h5a);
      check_word(32'h404, 32'hdeadbeef);
   endtask

   initial begin
      clock           = 1'b0;
      rst_n           = 1'b0;
      run             = 1'b0;
      load_enable     = 1'b0;
      load_address    = '0;
      load_value      = '0;
      inspect_address = '0;
      seed            = seed_start;
      pulse_reset();
      reset_and_run_gating();
      alu_operations();
      branches_and_loops();
      jumps_and_upper();
      load_store_round_trip();
      illegal_halt();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
logic/rv32i_pkg.sv
logic/rv32i_if.sv
logic/memory.sv
logic/fetch.sv
logic/decode.sv
logic/register_file.sv
logic/execute.sv
logic/rv32i_core_top.sv
sim/tb_rv32i.sv

//--- run.sh
#!/bin/sh
# build and run the rv32i testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_rv32i -f all.f -o tb_rv32i_sim; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_rv32i_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   echo "pass message not found"
   exit 1
fi
